//--- hw/conv_pkg.sv
package conv_pkg;

    localparam int PIX_W  = 8;
    localparam int COEF_W = 8;
    localparam int KSIZE  = 3;
    localparam int KTAPS  = KSIZE * KSIZE;

    // nine products of a 9-bit signed pixel and an 8-bit coefficient
    localparam int ACC_W  = 21;

    typedef logic [PIX_W-1:0] pixel_t;
    typedef logic signed [COEF_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    typedef struct packed {
        pixel_t left;
        pixel_t center;
        pixel_t right;
    } pix_row_t;

    // top.left sits in the msbs
    typedef struct packed {
        pix_row_t top;
        pix_row_t mid;
        pix_row_t bot;
    } window_t;

    typedef struct packed {
        coef_t left;
        coef_t center;
        coef_t right;
    } coef_row_t;

    // same shape as window_t so the taps line up bit for bit
    typedef struct packed {
        coef_row_t top;
        coef_row_t mid;
        coef_row_t bot;
    } kernel_t;

endpackage

//--- hw/conv_ctrl.sv
module conv_ctrl
    import conv_pkg::*;
#(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pix_req,
    input  logic wt_req,
    input  logic out_ack,
    input  logic mac_done,
    input  acc_t mac_sum,
    output logic pix_ack,
    output logic wt_ack,
    output logic out_req,
    output acc_t out_data,
    output logic pix_shift,
    output logic wt_shift,
    output logic mac_start
);

    localparam int COL_W = $clog2(IMG_W);
    localparam int ROW_W = $clog2(IMG_H);

    logic [COL_W-1:0] col_q;
    logic [ROW_W-1:0] row_q;
    logic             busy_q;
    logic             stall;
    logic             pix_take;
    logic             win_hit;
    logic             last_col;
    logic             last_row;

    // one window result in flight at a time, and the output handshake
    // has to be fully closed before the next pixel goes in
    assign stall    = (busy_q & win_hit) | out_req | out_ack;
    assign pix_take = pix_req & ~pix_ack & ~stall;
    assign pix_shift = pix_take;
    assign wt_shift  = wt_req & ~wt_ack;

    assign last_col = (col_q == COL_W'(IMG_W - 1));
    assign last_row = (row_q == ROW_W'(IMG_H - 1));

    // position of the pixel being taken, before the counters move
    assign win_hit = (row_q >= ROW_W'(KSIZE - 1)) && (col_q >= COL_W'(KSIZE - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pix_ack <= 1'b0;
        end else if (pix_take) begin
            pix_ack <= 1'b1;
        end else if (!pix_req) begin
            pix_ack <= 1'b0;
        end
    end

    // coefficient port never waits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wt_ack <= 1'b0;
        end else if (wt_shift) begin
            wt_ack <= 1'b1;
        end else if (!wt_req) begin
            wt_ack <= 1'b0;
        end
    end

    // raster position, wraps into the next frame
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (pix_take) begin
            if (last_col) begin
                col_q <= '0;
                row_q <= last_row ? '0 : row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end
    end

    // start one cycle late so the window registers hold the new pixel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mac_start <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            mac_start <= pix_take & win_hit;
            if (pix_take && win_hit) begin
                busy_q <= 1'b1;
            end else if (mac_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_req <= 1'b0;
        end else if (mac_done) begin
            out_req <= 1'b1;
        end else if (out_ack) begin
            out_req <= 1'b0;
        end
    end

    // held until the next result, so stable for the whole handshake
    always_ff @(posedge clk) begin
        if (mac_done) begin
            out_data <= mac_sum;
        end
    end

endmodule

//--- hw/line_buffer.sv
module line_buffer
    import conv_pkg::*;
#(
    parameter int IMG_W = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pix_shift,
    input  pixel_t  pix_data,
    output window_t window
);

    // one delay line for each row above the incoming one
    pixel_t  line_q [KSIZE-1][IMG_W];
    pixel_t  tap_out [KSIZE-1];
    window_t win_q;

    // oldest entry is the same column, one row further up
    always_comb begin
        for (int i = 0; i < KSIZE - 1; i++) begin
            tap_out[i] = line_q[i][IMG_W-1];
        end
    end

    always_ff @(posedge clk) begin
        if (pix_shift) begin
            line_q[0][0] <= pix_data;
            for (int i = 1; i < KSIZE - 1; i++) begin
                line_q[i][0] <= tap_out[i-1];
            end
            for (int i = 0; i < KSIZE - 1; i++) begin
                for (int j = 1; j < IMG_W; j++) begin
                    line_q[i][j] <= line_q[i][j-1];
                end
            end
        end
    end

    // rows move left, fresh column enters on the right
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_q <= '0;
        end else if (pix_shift) begin
            win_q.top <= {win_q.top.center, win_q.top.right, tap_out[1]};
            win_q.mid <= {win_q.mid.center, win_q.mid.right, tap_out[0]};
            win_q.bot <= {win_q.bot.center, win_q.bot.right, pix_data};
        end
    end

    assign window = win_q;

endmodule

//--- hw/weight_bank.sv
module weight_bank
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wt_shift,
    input  coef_t   wt_data,
    output kernel_t kernel
);

    // index KTAPS-1 is top-left, index 0 is bottom-right
    coef_t [KTAPS-1:0] chain_q;

    // first coefficient of a load ends up top-left after nine shifts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chain_q <= '0;
        end else if (wt_shift) begin
            chain_q <= {chain_q[KTAPS-2:0], wt_data};
        end
    end

    assign kernel = kernel_t'(chain_q);

endmodule

//--- hw/mac_array.sv
module mac_array
    import conv_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    mac_start,
    input  window_t window,
    input  kernel_t kernel,
    output acc_t    mac_sum,
    output logic    mac_done
);

    // zero-extended pixel times signed coefficient
    localparam int PROD_W = PIX_W + 1 + COEF_W;

    logic [KTAPS-1:0][PIX_W-1:0]  pix_flat;
    logic [KTAPS-1:0][COEF_W-1:0] coef_flat;
    logic signed [PROD_W-1:0]     prod_q [KTAPS];
    acc_t                         sum_d;
    acc_t                         sum_q;
    logic                         prod_vld_q;
    logic                         sum_vld_q;

    // window and kernel share one layout, so a flat view pairs the taps
    assign pix_flat  = window;
    assign coef_flat = kernel;

    always_ff @(posedge clk) begin
        if (mac_start) begin
            for (int i = 0; i < KTAPS; i++) begin
                prod_q[i] <= $signed({1'b0, pix_flat[i]}) * $signed(coef_flat[i]);
            end
        end
    end

    // adder tree between the two stages
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < KTAPS; i++) begin
            sum_d = sum_d + prod_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (prod_vld_q) begin
            sum_q <= sum_d;
        end
    end

    // per-stage valid, two starts can overlap
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_vld_q <= 1'b0;
            sum_vld_q  <= 1'b0;
        end else begin
            prod_vld_q <= mac_start;
            sum_vld_q  <= prod_vld_q;
        end
    end

    assign mac_sum  = sum_q;
    assign mac_done = sum_vld_q;

endmodule

//--- hw/conv3x3_top.sv
module conv3x3_top
    import conv_pkg::*;
#(
    parameter int IMG_W = 8,
    parameter int IMG_H = 6
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   pix_req,
    input  pixel_t pix_data,
    input  logic   wt_req,
    input  coef_t  wt_data,
    input  logic   out_ack,
    output logic   pix_ack,
    output logic   wt_ack,
    output logic   out_req,
    output acc_t   out_data
);

    logic    pix_shift;
    logic    wt_shift;
    logic    mac_start;
    logic    mac_done;
    acc_t    mac_sum;
    window_t window;
    kernel_t kernel;

    conv_ctrl #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) u_ctrl (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_req  (pix_req),
        .wt_req   (wt_req),
        .out_ack  (out_ack),
        .mac_done (mac_done),
        .mac_sum  (mac_sum),
        .pix_ack  (pix_ack),
        .wt_ack   (wt_ack),
        .out_req  (out_req),
        .out_data (out_data),
        .pix_shift(pix_shift),
        .wt_shift (wt_shift),
        .mac_start(mac_start)
    );

    line_buffer #(
        .IMG_W(IMG_W)
    ) u_line_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix_shift(pix_shift),
        .pix_data (pix_data),
        .window   (window)
    );

    weight_bank u_weight_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .wt_shift(wt_shift),
        .wt_data (wt_data),
        .kernel  (kernel)
    );

    mac_array u_mac_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .mac_start(mac_start),
        .window   (window),
        .kernel   (kernel),
        .mac_sum  (mac_sum),
        .mac_done (mac_done)
    );

endmodule

//--- bench/conv3x3_properties.sv
module conv3x3_properties
    import conv_pkg::*;
(
    input logic clk,
    input logic rst_n,
    input logic pix_req,
    input logic pix_ack,
    input logic out_req,
    input logic out_ack,
    input acc_t out_data
);
    timeunit 1ns;
    timeprecision 1ps;

    int assert_fails = 0;

    // result request holds until the receiver answers
    out_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        out_req && !out_ack |=> out_req)
        else begin
            $error("out_req dropped before out_ack");
            assert_fails++;
        end

    out_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
        $past(out_req) |-> $stable(out_data))
        else begin
            $error("out_data changed during the output handshake");
            assert_fails++;
        end

    pix_ack_release: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(pix_ack) |-> !$past(pix_req))
        else begin
            $error("pix_ack fell while pix_req was still high");
            assert_fails++;
        end

    // no new pixel while a result waits at the output
    pix_ack_blocked: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(pix_ack) |-> !$past(out_req))
        else begin
            $error("pix_ack rose while out_req was high");
            assert_fails++;
        end

endmodule

bind conv3x3_top conv3x3_properties u_props (
    .clk     (clk),
    .rst_n   (rst_n),
    .pix_req (pix_req),
    .pix_ack (pix_ack),
    .out_req (out_req),
    .out_ack (out_ack),
    .out_data(out_data)
);

//--- bench/conv3x3_tb.sv
module conv3x3_tb
    import conv_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMG_W     = 8;
    localparam int IMG_H     = 6;
    localparam int TIMEOUT   = 200;
    localparam int PER_FRAME = (IMG_W - 2) * (IMG_H - 2);

    logic   clk = 1'b0;
    logic   rst_n;
    logic   pix_req;
    pixel_t pix_data;
    logic   wt_req;
    coef_t  wt_data;
    logic   out_ack;
    logic   pix_ack;
    logic   wt_ack;
    logic   out_req;
    acc_t   out_data;

    int     seed = 32'h7b64;
    int     errors = 0;
    int     cycle_cnt = 0;
    int     kern [KTAPS];
    pixel_t img [2][IMG_H][IMG_W];
    int     expect_q [$];
    int     accept_q [$];
    logic   pix_ack_d;
    logic   out_req_d;

    conv3x3_top #(
        .IMG_W(IMG_W),
        .IMG_H(IMG_H)
    ) uut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_req (pix_req),
        .pix_data(pix_data),
        .wt_req  (wt_req),
        .wt_data (wt_data),
        .out_ack (out_ack),
        .pix_ack (pix_ack),
        .wt_ack  (wt_ack),
        .out_req (out_req),
        .out_data(out_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // a pixel accept must never overlap a pending result
    always @(posedge clk) begin
        if (rst_n && pix_ack && !pix_ack_d && out_req_d) begin
            errors++;
            $display("pixel accepted while out_req was high, cycle %0d", cycle_cnt);
        end
        pix_ack_d <= pix_ack;
        out_req_d <= out_req;
    end

    task automatic abort_run(input string what);
        errors++;
        $display("%s", what);
        $display("errors: %0d failed checks, %0d failed assertions",
                 errors, uut.u_props.assert_fails);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        errors++;
        $display("FAIL %s: expected %0d, actual %0d", name, expected, actual);
    endtask

    task automatic send_coef(input coef_t c);
        int waited;
        @(posedge clk);
        wt_req  <= 1'b1;
        wt_data <= c;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!wt_ack && waited < TIMEOUT);
        if (!wt_ack) abort_run("timeout waiting for wt_ack to rise");
        // ack one cycle after req, seen on the second sample
        if (waited != 2) report_mismatch("wt_ack latency", 2, waited);
        wt_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (wt_ack && waited < TIMEOUT);
        if (wt_ack) abort_run("timeout waiting for wt_ack to fall");
    endtask

    task automatic load_kernel();
        for (int k = 0; k < KTAPS; k++) begin
            send_coef(coef_t'(kern[k]));
        end
    endtask

    task automatic send_pixel(input pixel_t p, input bit hit);
        int waited;
        @(posedge clk);
        pix_req  <= 1'b1;
        pix_data <= p;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!pix_ack && waited < TIMEOUT);
        if (!pix_ack) abort_run("timeout waiting for pix_ack to rise");
        if (hit) accept_q.push_back(cycle_cnt);
        pix_req <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (pix_ack && waited < TIMEOUT);
        if (pix_ack) abort_run("timeout waiting for pix_ack to fall");
    endtask

    task automatic send_frames(input int nframes);
        for (int f = 0; f < nframes; f++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    send_pixel(img[f][r][c], (r >= KSIZE - 1) && (c >= KSIZE - 1));
                end
            end
        end
    endtask

    // model: identity picks the center pixel, otherwise the full window sum
    task automatic queue_expect(input int nframes, input bit identity);
        int sum;
        for (int f = 0; f < nframes; f++) begin
            for (int r = KSIZE - 1; r < IMG_H; r++) begin
                for (int c = KSIZE - 1; c < IMG_W; c++) begin
                    sum = 0;
                    for (int i = 0; i < KSIZE; i++) begin
                        for (int j = 0; j < KSIZE; j++) begin
                            sum += kern[i*KSIZE+j] * int'(img[f][r-2+i][c-2+j]);
                        end
                    end
                    expect_q.push_back(identity ? int'(img[f][r-1][c-1]) : sum);
                end
            end
        end
    endtask

    task automatic collect_outputs(input int count, input int max_delay, input string name);
        int waited;
        int delay;
        int actual;
        int expected;
        int accepted;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!out_req && waited < TIMEOUT);
            if (!out_req) abort_run({name, ": timeout waiting for a result"});
            actual   = out_data;
            expected = expect_q.pop_front();
            if (actual !== expected) report_mismatch({name, " out_data"}, expected, actual);
            if (accept_q.size() == 0) begin
                errors++;
                $display("%s: result arrived with no window pixel accepted", name);
            end else begin
                accepted = accept_q.pop_front();
                if (cycle_cnt - accepted != 3) begin
                    report_mismatch({name, " out_req latency"}, 3, cycle_cnt - accepted);
                end
            end
            delay = (max_delay > 0) ? $unsigned($random(seed)) % (max_delay + 1) : 0;
            repeat (delay) @(posedge clk);
            out_ack <= 1'b1;
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (out_req && waited < TIMEOUT);
            if (out_req) abort_run({name, ": timeout waiting for out_req to fall"});
            if (waited != 2) report_mismatch({name, " out_req release"}, 2, waited);
            out_ack <= 1'b0;
        end
    endtask

    task automatic check_idle(input string name);
        for (int n = 0; n < 20; n++) begin
            @(posedge clk);
            if (out_req) begin
                errors++;
                $display("%s: extra result after the last expected one", name);
                break;
            end
        end
    endtask

    task automatic run_frames(input string name, input int nframes, input int max_delay,
                              input bit identity);
        for (int f = 0; f < nframes; f++) begin
            for (int r = 0; r < IMG_H; r++) begin
                for (int c = 0; c < IMG_W; c++) begin
                    img[f][r][c] = pixel_t'($random(seed));
                end
            end
        end
        queue_expect(nframes, identity);
        fork
            send_frames(nframes);
            collect_outputs(nframes * PER_FRAME, max_delay, name);
        join
        check_idle(name);
    endtask

    task automatic random_kernel();
        for (int k = 0; k < KTAPS; k++) begin
            kern[k] = int'(coef_t'($random(seed)));
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        pix_req  = 1'b0;
        pix_data = '0;
        wt_req   = 1'b0;
        wt_data  = '0;
        out_ack  = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (pix_ack !== 1'b0) report_mismatch("reset pix_ack", 0, int'(pix_ack));
        if (wt_ack !== 1'b0) report_mismatch("reset wt_ack", 0, int'(wt_ack));
        if (out_req !== 1'b0) report_mismatch("reset out_req", 0, int'(out_req));

        // center tap only
        for (int k = 0; k < KTAPS; k++) begin
            kern[k] = 0;
        end
        kern[KTAPS/2] = 1;
        load_kernel();
        run_frames("identity kernel", 1, 0, 1'b1);

        random_kernel();
        load_kernel();
        run_frames("random kernel", 2, 0, 1'b0);
        run_frames("back-pressure", 1, 20, 1'b0);

        random_kernel();
        load_kernel();
        run_frames("kernel reload", 1, 0, 1'b0);

        $display("errors: %0d failed checks, %0d failed assertions",
                 errors, uut.u_props.assert_fails);
        if (errors == 0 && uut.u_props.assert_fails == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- conv3x3_top.f
hw/conv_pkg.sv
hw/conv_ctrl.sv
hw/line_buffer.sv
hw/weight_bank.sv
hw/mac_array.sv
hw/conv3x3_top.sv
bench/conv3x3_properties.sv
bench/conv3x3_tb.sv

//--- Makefile
# Verilator build and run for the 3x3 convolution engine

VERILATOR ?= verilator
TOP       ?= conv3x3_tb
FILELIST  ?= conv3x3_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps -Wall
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= PASS: all tests

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx '$(PASS_MSG)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
